// ==== hdl/sdhc_pkg.sv ====
// SD host controller shared definitions
// Register map, interrupt bit positions and state encodings
package sdhc_pkg;

  localparam logic [7:0] ADDR_ARGUMENT      = 8'h00;
  localparam logic [7:0] ADDR_COMMAND       = 8'h04; // [5:0] index, [7:6] response type
  localparam logic [7:0] ADDR_RESPONSE      = 8'h08;
  localparam logic [7:0] ADDR_RESP_INDEX    = 8'h0C;
  localparam logic [7:0] ADDR_PRESENT_STATE = 8'h10;
  localparam logic [7:0] ADDR_CLOCK_DIV     = 8'h14;
  localparam logic [7:0] ADDR_INT_STATUS    = 8'h18;
  localparam logic [7:0] ADDR_INT_ENABLE    = 8'h1C;

  localparam int unsigned INT_CMD_COMPLETE    = 0;
  localparam int unsigned INT_CMD_TIMEOUT     = 1;
  localparam int unsigned INT_CMD_CRC_ERR     = 2;
  localparam int unsigned INT_CMD_INDEX_ERR   = 3;
  localparam int unsigned INT_CMD_END_BIT_ERR = 4;

  localparam int unsigned CMD_TIMEOUT_SD_CYCLES = 64;
  localparam logic [7:0]  DIV_RESET             = 8'd0;

  typedef enum logic [1:0] {
    RESP_NONE  = 2'b00,
    RESP_SHORT = 2'b01
  } resp_type_e;

  typedef enum logic [2:0] {
    IDLE, WAIT_EDGE, SEND, WAIT_START, RECEIVE, FINISH
  } cmd_state_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

// ==== hdl/sdhc_axil_regs.sv ====
// SD host register block
// AXI4-Lite slave holding command, argument, divider and interrupt enable registers
`timescale 1ns/1ps

module sdhc_axil_regs import sdhc_pkg::*; #(
  parameter logic [7:0] DivReset = DIV_RESET
) (
  input  logic        clk_i,
  input  logic        software_reset_cmd_q,
  input  logic        awvalid_i,
  input  logic [7:0]  awaddr_i,
  output logic        awready_o,
  input  logic        wvalid_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic        wready_o,
  output logic        bvalid_o,
  output axi_resp_e   bresp_o,
  input  logic        bready_i,
  input  logic        arvalid_i,
  input  logic [7:0]  araddr_i,
  output logic        arready_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output axi_resp_e   rresp_o,
  input  logic        rready_i,
  input  logic        cmd_busy_i,
  input  logic        resp_valid_i,
  input  logic [5:0]  resp_index_i,
  input  logic [31:0] resp_status_i,
  input  logic [4:0]  int_status_i,
  output logic        cmd_start_o,
  output logic [5:0]  cmd_index_o,
  output logic [31:0] cmd_arg_o,
  output resp_type_e  resp_type_o,
  output logic [7:0]  clk_div_o,
  output logic [4:0]  int_clear_o,
  output logic [4:0]  int_enable_o
);

  logic        aw_ready_q;
  logic        b_valid_q;
  axi_resp_e   b_resp_q;
  logic        ar_ready_q;
  logic        r_valid_q;
  logic [31:0] r_data_q;
  logic        wr_en;
  logic        rd_en;
  logic        cmd_inhibit;
  logic        cmd_blocked;
  logic        cmd_start_q;
  logic [31:0] arg_q;
  logic [5:0]  cmd_index_q;
  resp_type_e  resp_type_q;
  logic [7:0]  clk_div_q;
  logic [4:0]  int_enable_q;
  logic [31:0] resp_q;
  logic [5:0]  resp_index_q;
  logic [31:0] rd_mux;

  assign wr_en       = aw_ready_q && awvalid_i && wvalid_i;
  assign rd_en       = ar_ready_q && arvalid_i;
  assign cmd_inhibit = cmd_busy_i || cmd_start_q; // Start pulse counts as busy
  assign cmd_blocked = wr_en && (awaddr_i == ADDR_COMMAND) && cmd_inhibit;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      aw_ready_q   <= 1'b0;
      b_valid_q    <= 1'b0;
      b_resp_q     <= OKAY;
      cmd_start_q  <= 1'b0;
      arg_q        <= '0;
      cmd_index_q  <= '0;
      resp_type_q  <= RESP_NONE;
      clk_div_q    <= DivReset;
      int_enable_q <= '0;
      resp_q       <= '0;
      resp_index_q <= '0;
    end else begin
      aw_ready_q  <= awvalid_i && wvalid_i && !b_valid_q && !aw_ready_q;
      cmd_start_q <= 1'b0;
      if (b_valid_q && bready_i) begin
        b_valid_q <= 1'b0;
      end
      if (wr_en) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= cmd_blocked ? SLVERR : OKAY;
        case (awaddr_i)
          ADDR_ARGUMENT: begin
            for (int b = 0; b < 4; b++) begin
              if (wstrb_i[b]) begin
                arg_q[8*b +: 8] <= wdata_i[8*b +: 8];
              end
            end
          end
          ADDR_COMMAND: begin
            if (!cmd_inhibit) begin
              cmd_index_q <= wdata_i[5:0];
              resp_type_q <= resp_type_e'(wdata_i[7:6]);
              cmd_start_q <= 1'b1;
            end
          end
          ADDR_CLOCK_DIV:  if (wstrb_i[0]) clk_div_q <= wdata_i[7:0];
          ADDR_INT_ENABLE: if (wstrb_i[0]) int_enable_q <= wdata_i[4:0];
          default: ;
        endcase
      end
      if (resp_valid_i) begin // Latched only when a response arrived
        resp_q       <= resp_status_i;
        resp_index_q <= resp_index_i;
      end
    end
  end

  always_comb begin
    case (araddr_i)
      ADDR_ARGUMENT:      rd_mux = arg_q;
      ADDR_COMMAND:       rd_mux = {24'b0, resp_type_q, cmd_index_q};
      ADDR_RESPONSE:      rd_mux = resp_q;
      ADDR_RESP_INDEX:    rd_mux = {26'b0, resp_index_q};
      ADDR_PRESENT_STATE: rd_mux = {31'b0, cmd_busy_i};
      ADDR_CLOCK_DIV:     rd_mux = {24'b0, clk_div_q};
      ADDR_INT_STATUS:    rd_mux = {27'b0, int_status_i};
      ADDR_INT_ENABLE:    rd_mux = {27'b0, int_enable_q};
      default:            rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      r_data_q   <= '0;
    end else begin
      ar_ready_q <= arvalid_i && !r_valid_q && !ar_ready_q;
      if (r_valid_q && rready_i) begin
        r_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
        r_data_q  <= rd_mux;
      end
    end
  end

  assign awready_o    = aw_ready_q;
  assign wready_o     = aw_ready_q;
  assign bvalid_o     = b_valid_q;
  assign bresp_o      = b_resp_q;
  assign arready_o    = ar_ready_q;
  assign rvalid_o     = r_valid_q;
  assign rdata_o      = r_data_q;
  assign rresp_o      = OKAY;
  assign cmd_start_o  = cmd_start_q;
  assign cmd_index_o  = cmd_index_q;
  assign cmd_arg_o    = arg_q;
  assign resp_type_o  = resp_type_q;
  assign clk_div_o    = clk_div_q;
  assign int_enable_o = int_enable_q;
  // Write-one-to-clear mask toward the interrupt block
  assign int_clear_o  = (wr_en && awaddr_i == ADDR_INT_STATUS && wstrb_i[0]) ? wdata_i[4:0] : '0;

endmodule

// ==== hdl/sd_clk_gen.sv ====
// SD bus clock generator
// Divides clk_i down and flags the cycle before each SD clock edge
`timescale 1ns/1ps

module sd_clk_gen #(
  parameter logic [7:0] DivReset = 8'd0
) (
  input  logic       clk_i,
  input  logic       software_reset_cmd_q,
  input  logic [7:0] clk_div_i,
  output logic       sd_clk_o,
  output logic       sd_rise_o,
  output logic       sd_fall_o
);

  logic [7:0] cnt_q;
  logic [7:0] div_q;
  logic       sd_clk_q;
  logic       term;

  assign term = (cnt_q == div_q);

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cnt_q    <= '0;
      div_q    <= DivReset;
      sd_clk_q <= 1'b0;
    end else if (term) begin
      cnt_q    <= '0;
      div_q    <= clk_div_i; // New divider only at terminal count
      sd_clk_q <= !sd_clk_q;
    end else begin
      cnt_q <= cnt_q + 8'd1;
    end
  end

  assign sd_clk_o  = sd_clk_q;
  assign sd_rise_o = term && !sd_clk_q;
  assign sd_fall_o = term && sd_clk_q;

endmodule

// ==== hdl/sd_cmd_engine.sv ====
// SD command line engine
// Sends 48-bit command frames with CRC7 and checks the short response
`timescale 1ns/1ps

module sd_cmd_engine import sdhc_pkg::*; #(
  parameter int unsigned TimeoutCycles = CMD_TIMEOUT_SD_CYCLES
) (
  input  logic        clk_i,
  input  logic        software_reset_cmd_q,
  input  logic        sd_rise_i,
  input  logic        sd_fall_i,
  input  logic        cmd_start_i,
  input  logic [5:0]  cmd_index_i,
  input  logic [31:0] cmd_arg_i,
  input  resp_type_e  resp_type_i,
  input  logic        sd_cmd_i,
  output logic        sd_cmd_o,
  output logic        sd_cmd_oe_o,
  output logic        cmd_busy_o,
  output logic        resp_valid_o,
  output logic [5:0]  resp_index_o,
  output logic [31:0] resp_status_o,
  output logic        done_o,
  output logic        timeout_o,
  output logic        crc_err_o,
  output logic        index_err_o,
  output logic        end_bit_err_o
);

  localparam int unsigned ToWidth = $clog2(TimeoutCycles + 1);

  cmd_state_e         state_q;
  resp_type_e         resp_type_q;
  logic [5:0]         bit_cnt_q;
  logic [ToWidth-1:0] to_cnt_q;
  logic [5:0]         index_q;
  logic [39:0]        tx_q;
  logic [46:0]        rx_q; // Response bits after the start bit
  logic [6:0]         crc_q;
  logic               sd_cmd_q;
  logic               sd_cmd_oe_q;
  logic               done_q;
  logic               timeout_q;
  logic               crc_err_q;
  logic               index_err_q;
  logic               end_bit_err_q;
  logic               resp_valid_q;

  // x^7 + x^3 + 1, one bit per call
  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
    logic fb;
    fb = crc[6] ^ din;
    return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      state_q       <= IDLE;
      resp_type_q   <= RESP_NONE;
      bit_cnt_q     <= '0;
      to_cnt_q      <= '0;
      sd_cmd_q      <= 1'b1;
      sd_cmd_oe_q   <= 1'b0;
      done_q        <= 1'b0;
      timeout_q     <= 1'b0;
      crc_err_q     <= 1'b0;
      index_err_q   <= 1'b0;
      end_bit_err_q <= 1'b0;
      resp_valid_q  <= 1'b0;
    end else begin
      done_q        <= 1'b0;
      timeout_q     <= 1'b0;
      crc_err_q     <= 1'b0;
      index_err_q   <= 1'b0;
      end_bit_err_q <= 1'b0;
      resp_valid_q  <= 1'b0;
      case (state_q)
        IDLE: begin
          if (cmd_start_i) begin
            resp_type_q <= resp_type_i;
            bit_cnt_q   <= '0;
            state_q     <= WAIT_EDGE;
          end
        end
        WAIT_EDGE, SEND: begin
          if (sd_fall_i) begin
            state_q     <= SEND;
            bit_cnt_q   <= bit_cnt_q + 6'd1;
            sd_cmd_oe_q <= 1'b1;
            if (bit_cnt_q < 6'd40) begin
              sd_cmd_q <= tx_q[39];
            end else if (bit_cnt_q < 6'd47) begin
              sd_cmd_q <= crc_q[6];
            end else if (bit_cnt_q == 6'd47) begin
              sd_cmd_q <= 1'b1; // End bit
            end else begin
              // Release the line for the card
              sd_cmd_oe_q <= 1'b0;
              sd_cmd_q    <= 1'b1;
              to_cnt_q    <= '0;
              state_q     <= (resp_type_q == RESP_NONE) ? FINISH : WAIT_START;
            end
          end
        end
        WAIT_START: begin
          if (sd_rise_i) begin
            if (!sd_cmd_i) begin
              bit_cnt_q <= 6'd1;
              state_q   <= RECEIVE;
            end else if (to_cnt_q == ToWidth'(TimeoutCycles - 1)) begin
              timeout_q <= 1'b1; // Frees the inhibit as well
              state_q   <= IDLE;
            end else begin
              to_cnt_q <= to_cnt_q + 1'b1;
            end
          end
        end
        RECEIVE: begin
          if (sd_rise_i) begin
            bit_cnt_q <= bit_cnt_q + 6'd1;
            if (bit_cnt_q == 6'd47) begin
              state_q <= FINISH;
            end
          end
        end
        FINISH: begin
          done_q  <= 1'b1;
          state_q <= IDLE;
          if (resp_type_q != RESP_NONE) begin
            resp_valid_q  <= 1'b1;
            crc_err_q     <= (rx_q[7:1] != crc_q);
            index_err_q   <= (rx_q[45:40] != index_q);
            end_bit_err_q <= !rx_q[0];
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Frame and CRC datapath
  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      tx_q    <= '0;
      index_q <= '0;
      rx_q    <= '0;
      crc_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cmd_start_i) begin
            tx_q    <= {2'b01, cmd_index_i, cmd_arg_i};
            index_q <= cmd_index_i;
            crc_q   <= '0;
          end
        end
        WAIT_EDGE, SEND: begin
          if (sd_fall_i) begin
            if (bit_cnt_q < 6'd40) begin
              tx_q  <= {tx_q[38:0], 1'b0};
              crc_q <= crc7_next(crc_q, tx_q[39]);
            end else if (bit_cnt_q < 6'd47) begin
              crc_q <= {crc_q[5:0], 1'b0};
            end
          end
        end
        WAIT_START: begin
          if (sd_rise_i && !sd_cmd_i) begin
            rx_q  <= '0;
            crc_q <= crc7_next(7'd0, 1'b0); // Start bit
          end
        end
        RECEIVE: begin
          if (sd_rise_i) begin
            rx_q <= {rx_q[45:0], sd_cmd_i};
            if (bit_cnt_q < 6'd40) begin
              crc_q <= crc7_next(crc_q, sd_cmd_i);
            end
          end
        end
        default: ;
      endcase
    end
  end

  assign sd_cmd_o      = sd_cmd_q;
  assign sd_cmd_oe_o   = sd_cmd_oe_q;
  assign cmd_busy_o    = (state_q != IDLE);
  assign resp_valid_o  = resp_valid_q;
  assign resp_index_o  = rx_q[45:40];
  assign resp_status_o = rx_q[39:8];
  assign done_o        = done_q;
  assign timeout_o     = timeout_q;
  assign crc_err_o     = crc_err_q;
  assign index_err_o   = index_err_q;
  assign end_bit_err_o = end_bit_err_q;

endmodule

// ==== hdl/sdhc_irq_ctrl.sv ====
// Interrupt status and mask
// Sticky event bits, write-one-to-clear, single interrupt line
`timescale 1ns/1ps

module sdhc_irq_ctrl (
  input  logic       clk_i,
  input  logic       software_reset_cmd_q,
  input  logic [4:0] event_i,
  input  logic [4:0] int_clear_i,
  input  logic [4:0] int_enable_i,
  output logic [4:0] int_status_o,
  output logic       interrupt_o
);

  logic [4:0] status_q;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~int_clear_i) | event_i; // Set beats clear
    end
  end

  assign int_status_o = status_q;
  assign interrupt_o  = |(status_q & int_enable_i);

endmodule

// ==== hdl/sdhc_top.sv ====
// SD host controller, command path
// Register port, SD clock divider, command engine and interrupts
`timescale 1ns/1ps

module sdhc_top import sdhc_pkg::*; #(
  parameter int unsigned TimeoutCycles = CMD_TIMEOUT_SD_CYCLES,
  parameter logic [7:0]  DivReset      = DIV_RESET
) (
  input  logic        clk_i,
  input  logic        software_reset_cmd_q,
  input  logic        awvalid_i,
  input  logic [7:0]  awaddr_i,
  output logic        awready_o,
  input  logic        wvalid_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic        wready_o,
  output logic        bvalid_o,
  output axi_resp_e   bresp_o,
  input  logic        bready_i,
  input  logic        arvalid_i,
  input  logic [7:0]  araddr_i,
  output logic        arready_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output axi_resp_e   rresp_o,
  input  logic        rready_i,
  output logic        sd_clk_o,
  output logic        sd_cmd_o,
  output logic        sd_cmd_oe_o,
  input  logic        sd_cmd_i,
  output logic        interrupt_o
);

  logic        cmd_start;
  logic [5:0]  cmd_index;
  logic [31:0] cmd_arg;
  resp_type_e  resp_type;
  logic [7:0]  clk_div;
  logic        cmd_busy;
  logic        resp_valid;
  logic [5:0]  resp_index;
  logic [31:0] resp_status;
  logic [4:0]  int_status;
  logic [4:0]  int_clear;
  logic [4:0]  int_enable;
  logic        sd_rise;
  logic        sd_fall;
  logic        cmd_done;
  logic        cmd_timeout;
  logic        crc_err;
  logic        index_err;
  logic        end_bit_err;
  logic [4:0]  events;

  assign events[INT_CMD_COMPLETE]    = cmd_done;
  assign events[INT_CMD_TIMEOUT]     = cmd_timeout;
  assign events[INT_CMD_CRC_ERR]     = crc_err;
  assign events[INT_CMD_INDEX_ERR]   = index_err;
  assign events[INT_CMD_END_BIT_ERR] = end_bit_err;

  sdhc_axil_regs #(
    .DivReset (DivReset)
  ) i_regs (
    .clk_i, .software_reset_cmd_q,
    .awvalid_i, .awaddr_i, .awready_o, .wvalid_i, .wdata_i, .wstrb_i, .wready_o,
    .bvalid_o, .bresp_o, .bready_i,
    .arvalid_i, .araddr_i, .arready_o, .rvalid_o, .rdata_o, .rresp_o, .rready_i,
    .cmd_busy_i    (cmd_busy),
    .resp_valid_i  (resp_valid),
    .resp_index_i  (resp_index),
    .resp_status_i (resp_status),
    .int_status_i  (int_status),
    .cmd_start_o   (cmd_start),
    .cmd_index_o   (cmd_index),
    .cmd_arg_o     (cmd_arg),
    .resp_type_o   (resp_type),
    .clk_div_o     (clk_div),
    .int_clear_o   (int_clear),
    .int_enable_o  (int_enable)
  );

  sd_clk_gen #(
    .DivReset (DivReset)
  ) i_sd_clk_gen (
    .clk_i, .software_reset_cmd_q,
    .clk_div_i (clk_div),
    .sd_clk_o,
    .sd_rise_o (sd_rise),
    .sd_fall_o (sd_fall)
  );

  sd_cmd_engine #(
    .TimeoutCycles (TimeoutCycles)
  ) i_cmd_engine (
    .clk_i, .software_reset_cmd_q,
    .sd_rise_i     (sd_rise),
    .sd_fall_i     (sd_fall),
    .cmd_start_i   (cmd_start),
    .cmd_index_i   (cmd_index),
    .cmd_arg_i     (cmd_arg),
    .resp_type_i   (resp_type),
    .sd_cmd_i,
    .sd_cmd_o,
    .sd_cmd_oe_o,
    .cmd_busy_o    (cmd_busy),
    .resp_valid_o  (resp_valid),
    .resp_index_o  (resp_index),
    .resp_status_o (resp_status),
    .done_o        (cmd_done),
    .timeout_o     (cmd_timeout),
    .crc_err_o     (crc_err),
    .index_err_o   (index_err),
    .end_bit_err_o (end_bit_err)
  );

  sdhc_irq_ctrl i_irq_ctrl (
    .clk_i, .software_reset_cmd_q,
    .event_i      (events),
    .int_clear_i  (int_clear),
    .int_enable_i (int_enable),
    .int_status_o (int_status),
    .interrupt_o
  );

endmodule

// ==== sim/sd_card_model.sv ====
// Behavioral SD card, CMD line only
// Answers each command with an R1-style frame, optionally corrupted
`timescale 1ns/1ps

module sd_card_model (
  input  logic       sd_clk_i,
  input  logic       cmd_i,
  input  logic [2:0] behavior_i, // 0 ok, 1 bad CRC, 2 wrong index, 3 bad end bit, 4 silent
  output logic       cmd_o,
  output logic       drive_o
);

  logic [47:0] frame;
  logic [47:0] resp;
  logic [39:0] body;
  logic [6:0]  crc;
  logic [5:0]  idx;
  logic        frame_ok;

  function automatic logic [6:0] crc7(input logic [39:0] d);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ d[i];
      c  = {c[5:0], 1'b0};
      if (fb) c = c ^ 7'h09;
    end
    return c;
  endfunction

  initial begin
    cmd_o   = 1'b1;
    drive_o = 1'b0;
    forever begin
      @(posedge sd_clk_i);
      if (cmd_i == 1'b0) begin
        frame[47] = 1'b0;
        for (int i = 46; i >= 0; i--) begin
          @(posedge sd_clk_i);
          frame[i] = cmd_i;
        end
        // Host frames with a bad CRC or framing get no reply
        frame_ok = frame[46] && frame[0] && (crc7(frame[47:8]) == frame[7:1]);
        idx  = (behavior_i == 3'd2) ? frame[45:40] + 6'd1 : frame[45:40];
        body = {2'b00, idx, frame[39:8] ^ 32'h0000_0900};
        crc  = crc7(body);
        if (behavior_i == 3'd1) crc = crc ^ 7'h01;
        resp = {body, crc, (behavior_i != 3'd3)};
        if (behavior_i != 3'd4 && frame_ok) begin
          repeat (2) @(negedge sd_clk_i);
          for (int i = 47; i >= 0; i--) begin
            @(negedge sd_clk_i);
            drive_o = 1'b1;
            cmd_o   = resp[i];
          end
          @(negedge sd_clk_i);
          drive_o = 1'b0;
          cmd_o   = 1'b1;
        end
      end
    end
  end

endmodule

// ==== sim/sdhc_checker.sv ====
// Result checker for the SD host testbench
// Captures AXI responses and read data, compares and reports per test
`timescale 1ns/1ps

module sdhc_checker import sdhc_pkg::*; (
  input logic        clk_i,
  input logic        bvalid_i,
  input logic        bready_i,
  input axi_resp_e   bresp_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i,
  input axi_resp_e   rresp_i
);

  axi_resp_e        last_bresp;
  axi_resp_e        last_rresp;
  logic [31:0]      last_rdata;
  int               errors = 0;
  int               tests = 0;
  logic [8*24-1:0]  test_name = "startup";
  logic             test_bad = 1'b0;
  string            bad_what;
  logic [31:0]      bad_exp, bad_act;

  always @(posedge clk_i) begin
    if (bvalid_i && bready_i) last_bresp <= bresp_i;
    if (rvalid_i && rready_i) begin
      last_rdata <= rdata_i;
      last_rresp <= rresp_i;
    end
  end

  // Card returns the argument with two status bits flipped
  function automatic logic [31:0] expected_status(input logic [31:0] arg);
    return arg ^ 32'h0000_0900;
  endfunction

  task automatic begin_test(input logic [8*24-1:0] name);
    test_name = name;
    test_bad  = 1'b0;
  endtask

  task automatic expect_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act && !test_bad) begin // First mismatch is kept
      test_bad = 1'b1;
      bad_what = what;
      bad_exp  = exp;
      bad_act  = act;
    end
  endtask

  task automatic expect_read(input string what, input logic [31:0] exp);
    expect_value(what, exp, last_rdata);
    expect_value({what, " rresp"}, {30'b0, OKAY}, {30'b0, last_rresp});
  endtask

  task automatic expect_bresp(input string what, input axi_resp_e exp);
    expect_value(what, {30'b0, exp}, {30'b0, last_bresp});
  endtask

  task automatic end_test();
    tests++;
    if (test_bad) begin
      errors++;
      $display("** Error %0s: %0s expected %h actual %h", test_name, bad_what, bad_exp, bad_act);
    end else begin
      $display("ok %0s", test_name);
    end
  endtask

  task automatic report_timeout(input string what);
    tests++;
    errors++;
    $display("Test %0s did not finish: %0s", test_name, what);
  endtask

  task automatic print_summary();
    $display("%0d tests run, %0d passed, %0d failed", tests, tests - errors, errors);
  endtask

endmodule

// ==== sim/sdhc_sva.sv ====
// Protocol assertions for the SD host controller
`timescale 1ns/1ps

module sdhc_sva (
  input logic        clk_i,
  input logic        software_reset_cmd_q,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i,
  input logic        sd_cmd_oe_i,
  input logic        cmd_busy_i,
  input logic        cmd_done_i,
  input logic        cmd_timeout_i
);

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("rvalid or rdata changed before rready");

  a_oe_reset: assert property (@(posedge clk_i) software_reset_cmd_q |=> !sd_cmd_oe_i)
    else $error("CMD output enabled after reset");

  a_busy_end: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    $fell(cmd_busy_i) |-> cmd_done_i || cmd_timeout_i)
    else $error("cmd_busy fell without done or timeout");

endmodule

bind sdhc_top sdhc_sva i_sva (
  .clk_i         (clk_i),
  .software_reset_cmd_q (software_reset_cmd_q),
  .bvalid_i      (bvalid_o),
  .bready_i      (bready_i),
  .rvalid_i      (rvalid_o),
  .rready_i      (rready_i),
  .rdata_i       (rdata_o),
  .sd_cmd_oe_i   (sd_cmd_oe_o),
  .cmd_busy_i    (cmd_busy),
  .cmd_done_i    (cmd_done),
  .cmd_timeout_i (cmd_timeout)
);

// ==== sim/tb_sdhc.sv ====
// SD host controller testbench
// Runs the command vectors, then busy, interrupt, divider and read stall tests
`timescale 1ns/1ps

module tb_sdhc import sdhc_pkg::*; ();

  logic        clk_i;
  logic        software_reset_cmd_q;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic [7:0]  awaddr, araddr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        awready, wready, bvalid, arready, rvalid;
  axi_resp_e   bresp, rresp;
  logic [31:0] rdata;
  logic        sd_clk, sd_cmd_out, sd_cmd_oe, interrupt;
  logic        card_cmd, card_drive, cmd_line, timed_out;
  logic [2:0]  card_behavior;

  // Open-drain style line with pull-up
  assign cmd_line = sd_cmd_oe ? sd_cmd_out : (card_drive ? card_cmd : 1'b1);

  always #10 clk_i = !clk_i;

  sdhc_top #(.TimeoutCycles(64), .DivReset(8'd0)) DUT (
    .clk_i, .software_reset_cmd_q,
    .awvalid_i(awvalid), .awaddr_i(awaddr), .awready_o(awready), .wvalid_i(wvalid),
    .wdata_i(wdata), .wstrb_i(wstrb), .wready_o(wready), .bvalid_o(bvalid),
    .bresp_o(bresp), .bready_i(bready), .arvalid_i(arvalid), .araddr_i(araddr),
    .arready_o(arready), .rvalid_o(rvalid), .rdata_o(rdata), .rresp_o(rresp),
    .rready_i(rready), .sd_clk_o(sd_clk), .sd_cmd_o(sd_cmd_out), .sd_cmd_oe_o(sd_cmd_oe),
    .sd_cmd_i(cmd_line), .interrupt_o(interrupt)
  );

  sd_card_model card (
    .sd_clk_i(sd_clk), .cmd_i(cmd_line), .behavior_i(card_behavior),
    .cmd_o(card_cmd), .drive_o(card_drive)
  );

  sdhc_checker chk (
    .clk_i, .bvalid_i(bvalid), .bready_i(bready), .bresp_i(bresp),
    .rvalid_i(rvalid), .rready_i(rready), .rdata_i(rdata), .rresp_i(rresp)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string what);
    chk.report_timeout(what);
    timed_out = 1'b1;
    forever @(posedge clk_i); // Parked until the watchdog ends the run
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    @(negedge clk_i);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > 100) abort_run("write address was never accepted");
    end while (!awready);
    chk.expect_value("wready with awready", 32'd1, 32'(wready));
    @(negedge clk_i);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid) begin
      @(negedge clk_i);
      n++;
      if (n > 100) abort_run("write response never arrived");
    end
    @(negedge clk_i); // Response left pending for a cycle
    bready = 1'b1;
    @(negedge clk_i);
    bready = 1'b0;
  endtask

  // Holds rready low for stall cycles once rvalid is up
  task automatic axi_read(input logic [7:0] addr, input int stall, output logic [31:0] data);
    int n;
    @(negedge clk_i);
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > 100) abort_run("read address was never accepted");
    end while (!arready);
    @(negedge clk_i);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      @(negedge clk_i);
      n++;
      if (n > 100) abort_run("read data never arrived");
    end
    data = rdata;
    for (int k = 0; k < stall; k++) begin
      @(negedge clk_i);
      chk.expect_value("rvalid held", 32'd1, 32'(rvalid));
      chk.expect_value("rdata held", data, rdata);
    end
    rready = 1'b1;
    @(negedge clk_i);
    rready = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input string what, input logic [31:0] exp);
    logic [31:0] d;
    axi_read(addr, 0, d);
    chk.expect_read(what, exp);
  endtask

  task automatic wait_interrupt();
    int n;
    n = 0;
    while (!interrupt) begin
      @(negedge clk_i);
      n++;
      if (n > 5000) abort_run("no interrupt after the command");
    end
  endtask

  task automatic issue_cmd(input logic [5:0] idx, input logic [1:0] rtype,
                           input logic [31:0] arg, input logic [2:0] beh);
    card_behavior = beh;
    axi_write(ADDR_INT_STATUS, 32'h1F);
    axi_write(ADDR_ARGUMENT, arg);
    axi_write(ADDR_COMMAND, {24'b0, rtype, idx});
  endtask

  task automatic run_cmd(input logic [8*24-1:0] name, input logic [5:0] idx,
                         input logic [1:0] rtype, input logic [31:0] arg,
                         input logic [2:0] beh, input logic [31:0] exp_status,
                         input logic [5:0] exp_idx, input logic [31:0] exp_int);
    chk.begin_test(name);
    issue_cmd(idx, rtype, arg, beh);
    wait_interrupt();
    read_check(ADDR_INT_STATUS, "int status", exp_int);
    read_check(ADDR_PRESENT_STATE, "cmd busy", 32'd0);
    read_check(ADDR_RESPONSE, "response", exp_status);
    read_check(ADDR_RESP_INDEX, "resp index", {26'b0, exp_idx});
    chk.end_test();
  endtask

  initial begin
    wait (timed_out);
    chk.print_summary();
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int fd;
    int r;
    logic [8*24-1:0]  tok;
    logic [8*128-1:0] rest;
    logic [5:0]  idx, eidx;
    logic [1:0]  rtype;
    logic [31:0] arg, es, eint, seed, d;
    logic [2:0]  beh;
    int          cycles;
    clk_i = 1'b0;
    software_reset_cmd_q = 1'b1;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '0;
    timed_out = 1'b0;
    card_behavior = 3'd4;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    software_reset_cmd_q = 1'b0;
    axi_write(ADDR_INT_ENABLE, 32'h1F);

    fd = $fopen("sim/cmd_vectors.txt", "r");
    if (fd == 0) abort_run("vectors file could not be opened");
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        r = $fgets(rest, fd);
      end else begin
        r = $fscanf(fd, "%h %h %h %d %h %h %h", idx, rtype, arg, beh, es, eidx, eint);
        if (r != 7) abort_run("vectors line is malformed");
        run_cmd(tok, idx, rtype, arg, beh, es, eidx, eint);
      end
    end
    $fclose(fd);

    chk.begin_test("write_while_busy");
    issue_cmd(6'h08, RESP_SHORT, 32'hCAFE_0001, 3'd0);
    chk.expect_bresp("first command bresp", OKAY);
    axi_write(ADDR_COMMAND, {24'b0, RESP_SHORT, 6'h02});
    chk.expect_bresp("blocked command bresp", SLVERR);
    wait_interrupt();
    read_check(ADDR_INT_STATUS, "int status", 32'h01);
    read_check(ADDR_RESP_INDEX, "resp index", 32'h08);
    read_check(ADDR_RESPONSE, "response", chk.expected_status(32'hCAFE_0001));
    chk.end_test();

    chk.begin_test("irq_mask_clear");
    issue_cmd(6'h0D, RESP_SHORT, 32'h0000_4444, 3'd1);
    wait_interrupt();
    axi_write(ADDR_INT_ENABLE, 32'h02);
    chk.expect_value("irq, timeout only enabled", 32'd0, 32'(interrupt));
    axi_write(ADDR_INT_ENABLE, 32'h04);
    chk.expect_value("irq, crc enabled", 32'd1, 32'(interrupt));
    axi_write(ADDR_INT_STATUS, 32'h04);
    chk.expect_value("irq after crc clear", 32'd0, 32'(interrupt));
    read_check(ADDR_INT_STATUS, "status after clear", 32'h01);
    axi_write(ADDR_INT_ENABLE, 32'h1F);
    chk.expect_value("irq, all enabled", 32'd1, 32'(interrupt));
    chk.end_test();

    chk.begin_test("clock_divider_3");
    axi_write(ADDR_CLOCK_DIV, 32'd3);
    measure_sd_period(cycles);
    chk.expect_value("sd_clk period", 32'd8, 32'(cycles));
    read_check(ADDR_CLOCK_DIV, "divider readback", 32'd3);
    chk.end_test();

    seed = 32'h48bb_b735;
    for (int k = 0; k < 3; k++) begin
      seed = xorshift32(seed);
      $sformat(tok, "random_%0d", k);
      run_cmd(tok, 6'h11, RESP_SHORT, seed, 3'd0, chk.expected_status(seed), 6'h11, 32'h01);
    end

    chk.begin_test("read_stall");
    axi_read(ADDR_RESPONSE, 5, d);
    chk.expect_read("response", chk.expected_status(seed));
    chk.end_test();

    chk.print_summary();
    if (chk.errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  task automatic measure_sd_period(output int cycles);
    int   n;
    int   rises;
    logic prev;
    prev   = sd_clk;
    rises  = 0;
    cycles = 0;
    n      = 0;
    while (rises < 3) begin
      @(negedge clk_i);
      n++;
      if (n > 200) abort_run("sd_clk stopped toggling");
      if (rises >= 2) cycles++;
      if (sd_clk && !prev) rises++;
      prev = sd_clk;
    end
  endtask

endmodule

// ==== sim/cmd_vectors.txt ====
# name index(hex) resp_type(hex) argument(hex) card_behavior(dec)
# expected: response(hex) resp_index(hex) int_status(hex)
# card_behavior 0 ok, 1 bad crc, 2 wrong index, 3 bad end bit, 4 silent
normal_cmd8        08 1 000001AA 0 000008AA 08 01
silent_cmd55       37 1 00000000 4 000008AA 08 02
after_timeout      11 1 12345678 0 12345F78 11 01
bad_crc            0D 1 00010000 1 00010900 0D 05
wrong_index        10 1 00000200 2 00000B00 11 09
bad_end_bit        06 1 80000001 3 80000901 06 11
resp_none_cmd0     00 0 00000000 4 80000901 06 01

// ==== compile.f ====
hdl/sdhc_pkg.sv
hdl/sdhc_axil_regs.sv
hdl/sd_clk_gen.sv
hdl/sd_cmd_engine.sv
hdl/sdhc_irq_ctrl.sv
hdl/sdhc_top.sv
sim/sd_card_model.sv
sim/sdhc_checker.sv
sim/sdhc_sva.sv
sim/tb_sdhc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SD host controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module tb_sdhc \
    -Mdir obj_dir -o tb_sdhc; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sdhc > sim.log 2>&1
run_status=$?
cat sim.log

if [ "$run_status" -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
fi
exit 1
